// ==== filelist.f ====
source/hyper_pkg.sv
source/hyper_chan_regs.sv
source/hyper_rr_arbiter.sv
source/hyper_trans_fifo.sv
source/hyper_read_ctrl.sv
source/hyper_rx_pack.sv
source/udma_hyperbus.sv
tests/hyper_asserts.sv
tests/tb_udma_hyperbus.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and search the log for the fail message
rm -rf obj_dir sim.log build.log
verilator --binary --assert -Wno-fatal --top-module tb_udma_hyperbus -f filelist.f -o tb_sim \
   > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim +verilator+error+limit+100 > sim.log 2>&1 || echo "Simulation exited with an error" >> sim.log
cat sim.log
grep -q "Verification failed" sim.log && exit 1 || grep -q "Verification passed" sim.log

// ==== tests/tb_udma_hyperbus.sv ====
// Testbench for the HyperBus read path
// Clock and reset, register accesses, PHY model,
// uDMA sink with expected words, test sequence

module tb_udma_hyperbus
   import hyper_pkg::*;
();

   localparam int NB_CH      = 4;
   localparam int FIFO_DEPTH = 4;
   localparam int WAIT_LIMIT = 4000;

   logic                  clk = 1'b0;
   logic                  rst_i = 1'b1;
   cfg_data_t             cfg_data_i;
   cfg_addr_t             cfg_addr_i;
   logic [NB_CH-1:0]      cfg_valid_i;
   logic                  cfg_rwn_i;
   cfg_data_t [NB_CH-1:0] cfg_data_o;
   logic [NB_CH-1:0]      cfg_ready_o;
   logic [NB_CH-1:0]      evt_eot_o;
   logic                  trans_valid_o;
   logic                  trans_ready_i = 1'b0;
   phy_trans_t            trans_o;
   logic                  rx_valid_i = 1'b0;
   phy_word_t             rx_data_i = '0;
   logic                  rx_ready_o;
   udma_word_t            rx_data_udma_o;
   logic                  rx_valid_udma_o;
   logic                  rx_ready_udma_i = 1'b0;

   logic [31:0]  lcg_state = 32'h4f8e_87ad;
   string        test_name = "reset";
   int           err_cnt = 0;
   int           timeout_cnt = 0;
   int           eot_cnt [NB_CH] = '{default: 0};
   int           last_gnt = NB_CH - 1;
   int           bp_level = 1;
   phy_trans_t   exp_bursts [$];
   phy_trans_t   sink_q [$];
   phy_trans_t   sink_tr = '0;
   int           sink_n = 0;
   int           sink_left = 0;
   phy_trans_t   phy_tr = '0;
   int           phy_n = 0;
   int           phy_left = 0;
   int           tr_delay = -1;
   hyper_addr_t  ch_addr [NB_CH];
   burst_len_t   ch_len [NB_CH];

   udma_hyperbus #(
      .NB_CH      ( NB_CH      ),
      .FIFO_DEPTH ( FIFO_DEPTH )
   ) dut_i (
      .sys_clk_i       ( clk             ),
      .rst_i           ( rst_i           ),
      .cfg_data_i      ( cfg_data_i      ),
      .cfg_addr_i      ( cfg_addr_i      ),
      .cfg_valid_i     ( cfg_valid_i     ),
      .cfg_rwn_i       ( cfg_rwn_i       ),
      .cfg_data_o      ( cfg_data_o      ),
      .cfg_ready_o     ( cfg_ready_o     ),
      .evt_eot_o       ( evt_eot_o       ),
      .trans_valid_o   ( trans_valid_o   ),
      .trans_ready_i   ( trans_ready_i   ),
      .trans_o         ( trans_o         ),
      .rx_valid_i      ( rx_valid_i      ),
      .rx_data_i       ( rx_data_i       ),
      .rx_ready_o      ( rx_ready_o      ),
      .rx_data_udma_o  ( rx_data_udma_o  ),
      .rx_valid_udma_o ( rx_valid_udma_o ),
      .rx_ready_udma_i ( rx_ready_udma_i )
   );

   always #2 clk = ~clk;

   function automatic int unsigned next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return {16'h0000, lcg_state[31:16]};
   endfunction

   function automatic void check_value(input string what, input logic [63:0] exp,
                                       input logic [63:0] act);
      if (exp !== act)
      begin
         err_cnt++;
         $display("ERR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      end
   endfunction

   function automatic void report_counts();
      $display("Errors: %0d value, %0d timeout, %0d assertion",
               err_cnt, timeout_cnt, dut_i.u_asserts.fail_count);
   endfunction

   ////////////////////////////////////////
   // PHY model
   ////////////////////////////////////////
   function automatic void take_burst(input phy_trans_t act);
      phy_trans_t exp;
      if (exp_bursts.size() == 0)
      begin
         err_cnt++;
         $display("PHY burst at address %0h issued with no read outstanding", act.address);
      end
      else
      begin
         exp = exp_bursts.pop_front();
         check_value("burst", exp, act);
      end
      phy_tr   = act;
      phy_n    = 0;
      phy_left = int'(act.burst);
   endfunction

   always @(posedge clk)
   begin
      if (rst_i)
      begin
         phy_left = 0;
         tr_delay = -1;
      end
      else
      begin
         if (trans_valid_o && trans_ready_i)
            take_burst(trans_o);
         if (rx_valid_i && rx_ready_o)
         begin
            phy_n++;
            phy_left--;
         end
      end
      #1;
      // Accept after 0 to 3 cycles
      trans_ready_i = 1'b0;
      if (trans_valid_o)
      begin
         if (tr_delay < 0)
            tr_delay = int'(next_rand() % 4);
         if (tr_delay == 0)
            trans_ready_i = 1'b1;
         tr_delay--;
      end
      rx_valid_i = (phy_left > 0) && (next_rand() % 4 != 0);
      rx_data_i  = phy_word_t'(phy_tr.address[15:0] + phy_n);
   end

   ////////////////////////////////////////
   // uDMA sink
   ////////////////////////////////////////
   function automatic void check_udma_word(input udma_word_t act);
      udma_word_t exp;
      phy_word_t  lo;
      if (sink_left == 0)
      begin
         if (sink_q.size() == 0)
         begin
            err_cnt++;
            $display("uDMA word %0h arrived with no burst outstanding", act);
            return;
         end
         sink_tr   = sink_q.pop_front();
         sink_n    = 0;
         sink_left = int'(sink_tr.burst);
      end
      lo = phy_word_t'(sink_tr.address[15:0] + sink_n);
      if (sink_left == 1)
      begin
         exp       = {16'h0000, lo};
         sink_left = 0;
      end
      else
      begin
         exp       = {lo + 16'd1, lo};
         sink_left = sink_left - 2;
      end
      sink_n = sink_n + 2;
      check_value("udma word", exp, act);
   endfunction

   always @(posedge clk)
   begin
      if (!rst_i && rx_valid_udma_o && rx_ready_udma_i)
         check_udma_word(rx_data_udma_o);
      #1;
      rx_ready_udma_i = (next_rand() % 4) >= bp_level;
   end

   always @(posedge clk)
   begin
      if (!rst_i)
      begin
         for (int i = 0; i < NB_CH; i++)
            eot_cnt[i] += int'(evt_eot_o[i]);
      end
   end

   ////////////////////////////////////////
   // Register accesses
   ////////////////////////////////////////
   task automatic cfg_access(input logic [NB_CH-1:0] mask, input logic rwn,
                             input cfg_addr_t addr, input cfg_data_t wdata,
                             output cfg_data_t rdata);
      int ch;
      ch = 0;
      for (int i = NB_CH - 1; i >= 0; i--)
      begin
         if (mask[i])
            ch = i;
      end
      cfg_valid_i = mask;
      cfg_rwn_i   = rwn;
      cfg_addr_i  = addr;
      cfg_data_i  = wdata;
      @(posedge clk);
      #1;
      cfg_valid_i = '0;
      // Ready and read data one cycle after the valid
      check_value("cfg_ready_o", 64'(mask), 64'(cfg_ready_o));
      rdata = cfg_data_o[ch];
   endtask

   task automatic cfg_write(input logic [NB_CH-1:0] mask, input cfg_addr_t addr,
                            input cfg_data_t data);
      cfg_data_t unused;
      cfg_access(mask, 1'b0, addr, data, unused);
   endtask

   task automatic cfg_read(input int ch, input cfg_addr_t addr, output cfg_data_t data);
      logic [NB_CH-1:0] one_hot;
      one_hot     = '0;
      one_hot[ch] = 1'b1;
      cfg_access(one_hot, 1'b1, addr, '0, data);
   endtask

   function automatic bit transfers_done(input logic [NB_CH-1:0] mask);
      for (int i = 0; i < NB_CH; i++)
      begin
         if (mask[i] && eot_cnt[i] == 0)
            return 1'b0;
      end
      return (exp_bursts.size() == 0) && (sink_q.size() == 0) && (sink_left == 0);
   endfunction

   // Program, start together, wait for all end-of-transfer events
   task automatic run_reads(input logic [NB_CH-1:0] mask, input logic extra_start);
      phy_trans_t       tr;
      int               ch;
      int               base;
      int               cycles;
      cfg_data_t        rd;
      logic [NB_CH-1:0] one_hot;
      for (int i = 0; i < NB_CH; i++)
      begin
         eot_cnt[i] = 0;
         if (mask[i])
         begin
            one_hot    = '0;
            one_hot[i] = 1'b1;
            cfg_write(one_hot, REG_ADDR, ch_addr[i]);
            cfg_write(one_hot, REG_LEN, cfg_data_t'(ch_len[i]));
         end
      end
      // Grant order starts one past the last grant
      base = last_gnt;
      for (int k = 1; k <= NB_CH; k++)
      begin
         ch = (base + k) % NB_CH;
         if (mask[ch])
         begin
            tr.address = ch_addr[ch];
            tr.burst   = ch_len[ch];
            exp_bursts.push_back(tr);
            sink_q.push_back(tr);
            last_gnt = ch;
         end
      end
      cfg_write(mask, REG_CMD, 32'h1);
      if (extra_start)
      begin
         one_hot           = '0;
         one_hot[last_gnt] = 1'b1;
         cfg_write(one_hot, REG_CMD, 32'h1);
      end
      cycles = 0;
      while (!transfers_done(mask) && cycles < WAIT_LIMIT)
      begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (!transfers_done(mask))
      begin
         timeout_cnt++;
         $display("Timeout in %s: reads on channels %b did not finish", test_name, mask);
      end
      repeat (6) @(posedge clk);
      #1;
      for (int i = 0; i < NB_CH; i++)
      begin
         check_value($sformatf("eot count ch%0d", i), mask[i] ? 64'd1 : 64'd0, eot_cnt[i]);
         if (mask[i])
         begin
            cfg_read(i, REG_CMD, rd);
            check_value($sformatf("busy ch%0d", i), 64'd0, 64'(rd[0]));
         end
      end
   endtask

   initial
   begin : watchdog
      repeat (40000) @(posedge clk);
      $display("Simulation did not finish within 40000 cycles");
      report_counts();
      $display("Verification failed");
      $finish;
   end

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////
   initial
   begin : main_seq
      cfg_data_t        rd;
      cfg_data_t        val;
      logic [NB_CH-1:0] mask;
      rst_i       = 1'b1;
      cfg_data_i  = '0;
      cfg_addr_i  = '0;
      cfg_valid_i = '0;
      cfg_rwn_i   = 1'b1;
      repeat (3) @(posedge clk);
      #1;
      rst_i = 1'b0;

      test_name = "reset";
      check_value("trans_valid_o", 64'd0, 64'(trans_valid_o));
      check_value("rx_ready_o", 64'd0, 64'(rx_ready_o));
      check_value("rx_valid_udma_o", 64'd0, 64'(rx_valid_udma_o));
      check_value("evt_eot_o", 64'd0, 64'(evt_eot_o));
      for (int i = 0; i < NB_CH; i++)
      begin
         cfg_read(i, REG_CMD, rd);
         check_value("busy", 64'd0, 64'(rd[0]));
      end

      test_name = "regs";
      for (int i = 0; i < NB_CH; i++)
      begin
         val = (next_rand() << 16) | next_rand();
         cfg_write(NB_CH'(1 << i), REG_ADDR, val);
         cfg_read(i, REG_ADDR, rd);
         check_value("addr readback", val, rd);
         val = next_rand() & 32'h0000_ffff;
         cfg_write(NB_CH'(1 << i), REG_LEN, val);
         cfg_read(i, REG_LEN, rd);
         check_value("len readback", val, rd);
      end

      test_name  = "even";
      ch_addr[1] = 32'h0002_1f3c;
      ch_len[1]  = 16'd8;
      run_reads(4'b0010, 1'b0);

      // Low half wraps past ffff
      test_name  = "odd";
      ch_addr[2] = 32'h0003_fffe;
      ch_len[2]  = 16'd7;
      run_reads(4'b0100, 1'b0);

      test_name = "all channels";
      for (int i = 0; i < NB_CH; i++)
         ch_addr[i] = 32'h0010_0000 + i * 32'h40;
      ch_len[0] = 16'd6;
      ch_len[1] = 16'd5;
      ch_len[2] = 16'd10;
      ch_len[3] = 16'd1;
      run_reads(4'b1111, 1'b1);

      test_name = "back-pressure";
      bp_level  = 3;
      for (int r = 0; r < 4; r++)
      begin
         for (int i = 0; i < NB_CH; i++)
         begin
            ch_addr[i] = (next_rand() << 16) | next_rand();
            ch_len[i]  = burst_len_t'(1 + next_rand() % 12);
         end
         mask = NB_CH'(1 + next_rand() % 15);
         run_reads(mask, 1'b0);
      end

      report_counts();
      if (err_cnt == 0 && timeout_cnt == 0 && dut_i.u_asserts.fail_count == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

// ==== tests/hyper_asserts.sv ====
// Protocol assertions for the HyperBus read path
// PHY request hold, uDMA output hold, reset values,
// single-cycle end-of-transfer events, and the bind to the top level

module hyper_asserts
   import hyper_pkg::*;
#(
   parameter int NB_CH = 4
)
(
   input logic             sys_clk_i,
   input logic             rst_i,
   input logic             trans_valid_i,
   input logic             trans_ready_i,
   input phy_trans_t       trans_i,
   input logic             rx_ready_i,
   input logic             udma_valid_i,
   input logic             udma_ready_i,
   input udma_word_t       udma_data_i,
   input logic [NB_CH-1:0] eot_i,
   input logic [NB_CH-1:0] cfg_ready_i
);

   int fail_count = 0;

   // PHY request held until accepted
   a_trans_held: assert property (@(posedge sys_clk_i) disable iff (rst_i)
      trans_valid_i && !trans_ready_i |=> trans_valid_i && $stable(trans_i))
   else
   begin
      $error("PHY request dropped or changed while stalled");
      fail_count++;
   end

   a_udma_held: assert property (@(posedge sys_clk_i) disable iff (rst_i)
      udma_valid_i && !udma_ready_i |=> udma_valid_i && $stable(udma_data_i))
   else
   begin
      $error("uDMA word dropped or changed while stalled");
      fail_count++;
   end

   // First cycle out of reset
   a_reset_idle: assert property (@(posedge sys_clk_i)
      $fell(rst_i) |-> !trans_valid_i && !rx_ready_i && !udma_valid_i
                       && (eot_i == '0) && (cfg_ready_i == '0))
   else
   begin
      $error("Control outputs active right after reset");
      fail_count++;
   end

   a_eot_pulse: assert property (@(posedge sys_clk_i) disable iff (rst_i)
      (eot_i & $past(eot_i)) == '0)
   else
   begin
      $error("End-of-transfer event longer than one cycle");
      fail_count++;
   end

endmodule

bind udma_hyperbus hyper_asserts #(
   .NB_CH ( NB_CH )
) u_asserts (
   .sys_clk_i     ( sys_clk_i       ),
   .rst_i         ( rst_i           ),
   .trans_valid_i ( trans_valid_o   ),
   .trans_ready_i ( trans_ready_i   ),
   .trans_i       ( trans_o         ),
   .rx_ready_i    ( rx_ready_o      ),
   .udma_valid_i  ( rx_valid_udma_o ),
   .udma_ready_i  ( rx_ready_udma_i ),
   .udma_data_i   ( rx_data_udma_o  ),
   .eot_i         ( evt_eot_o       ),
   .cfg_ready_i   ( cfg_ready_o     )
);

// ==== source/udma_hyperbus.sv ====
// HyperBus read controller for the uDMA, top level
// Channel registers, round-robin arbiter, command FIFO,
// read controller and rx packer

module udma_hyperbus
   import hyper_pkg::*;
#(
   parameter int NB_CH      = 4,
   parameter int FIFO_DEPTH = 4
)
(
   input  logic                    sys_clk_i,
   input  logic                    rst_i,

   input  cfg_data_t               cfg_data_i,
   input  cfg_addr_t               cfg_addr_i,
   input  logic [NB_CH-1:0]        cfg_valid_i,
   input  logic                    cfg_rwn_i,
   output cfg_data_t [NB_CH-1:0]   cfg_data_o,
   output logic [NB_CH-1:0]        cfg_ready_o,
   output logic [NB_CH-1:0]        evt_eot_o,

   output logic                    trans_valid_o,
   input  logic                    trans_ready_i,
   output phy_trans_t              trans_o,

   input  logic                    rx_valid_i,
   input  phy_word_t               rx_data_i,
   output logic                    rx_ready_o,

   output udma_word_t              rx_data_udma_o,
   output logic                    rx_valid_udma_o,
   input  logic                    rx_ready_udma_i
);

   localparam int ID_W = (NB_CH > 1) ? $clog2(NB_CH) : 1;

   logic [NB_CH-1:0]       ch_req;
   logic [NB_CH-1:0]       ch_gnt;
   hyper_cmd_t [NB_CH-1:0] ch_cmd;

   logic                   push;
   hyper_cmd_t             arb_cmd;
   logic [ID_W-1:0]        arb_id;
   logic                   fifo_full;
   logic                   fifo_valid;
   hyper_cmd_t             fifo_cmd;
   logic [ID_W-1:0]        fifo_id;
   logic                   pop;

   logic                   word_valid;
   phy_word_t              word;
   logic                   word_last;
   logic                   pack_ready;
   logic                   done_valid;
   logic [ID_W-1:0]        done_id;

   ////////////////////////////////////////
   // Channels
   ////////////////////////////////////////
   for (genvar i = 0; i < NB_CH; i++)
   begin : gen_ch
      hyper_chan_regs u_regs (
         .sys_clk_i   ( sys_clk_i                                   ),
         .rst_i       ( rst_i                                       ),
         .cfg_data_i  ( cfg_data_i                                  ),
         .cfg_addr_i  ( cfg_addr_i                                  ),
         .cfg_valid_i ( cfg_valid_i[i]                              ),
         .cfg_rwn_i   ( cfg_rwn_i                                   ),
         .cfg_ready_o ( cfg_ready_o[i]                              ),
         .cfg_data_o  ( cfg_data_o[i]                               ),
         .cmd_req_o   ( ch_req[i]                                   ),
         .cmd_o       ( ch_cmd[i]                                   ),
         .cmd_gnt_i   ( ch_gnt[i]                                   ),
         .done_i      ( done_valid && (done_id == ID_W'(i))         ),
         .evt_eot_o   ( evt_eot_o[i]                                )
      );
   end

   hyper_rr_arbiter #(
      .NB_CH ( NB_CH )
   ) u_arbiter (
      .sys_clk_i ( sys_clk_i ),
      .rst_i     ( rst_i     ),
      .req_i     ( ch_req    ),
      .cmd_i     ( ch_cmd    ),
      .full_i    ( fifo_full ),
      .gnt_o     ( ch_gnt    ),
      .push_o    ( push      ),
      .cmd_o     ( arb_cmd   ),
      .id_o      ( arb_id    )
   );

   hyper_trans_fifo #(
      .NB_CH      ( NB_CH      ),
      .FIFO_DEPTH ( FIFO_DEPTH )
   ) u_trans_fifo (
      .sys_clk_i ( sys_clk_i  ),
      .rst_i     ( rst_i      ),
      .push_i    ( push       ),
      .cmd_i     ( arb_cmd    ),
      .id_i      ( arb_id     ),
      .full_o    ( fifo_full  ),
      .pop_i     ( pop        ),
      .valid_o   ( fifo_valid ),
      .cmd_o     ( fifo_cmd   ),
      .id_o      ( fifo_id    )
   );

   ////////////////////////////////////////
   // Read path
   ////////////////////////////////////////
   hyper_read_ctrl #(
      .NB_CH ( NB_CH )
   ) u_read_ctrl (
      .sys_clk_i     ( sys_clk_i     ),
      .rst_i         ( rst_i         ),
      .fifo_valid_i  ( fifo_valid    ),
      .fifo_cmd_i    ( fifo_cmd      ),
      .fifo_id_i     ( fifo_id       ),
      .pop_o         ( pop           ),
      .trans_valid_o ( trans_valid_o ),
      .trans_ready_i ( trans_ready_i ),
      .trans_o       ( trans_o       ),
      .rx_valid_i    ( rx_valid_i    ),
      .rx_data_i     ( rx_data_i     ),
      .rx_ready_o    ( rx_ready_o    ),
      .pack_ready_i  ( pack_ready    ),
      .word_valid_o  ( word_valid    ),
      .word_o        ( word          ),
      .word_last_o   ( word_last     ),
      .done_valid_o  ( done_valid    ),
      .done_id_o     ( done_id       )
   );

   hyper_rx_pack u_rx_pack (
      .sys_clk_i       ( sys_clk_i       ),
      .rst_i           ( rst_i           ),
      .word_valid_i    ( word_valid      ),
      .word_i          ( word            ),
      .word_last_i     ( word_last       ),
      .ready_o         ( pack_ready      ),
      .rx_data_udma_o  ( rx_data_udma_o  ),
      .rx_valid_udma_o ( rx_valid_udma_o ),
      .rx_ready_udma_i ( rx_ready_udma_i )
   );

endmodule

// ==== source/hyper_rx_pack.sv ====
// Packs pairs of 16-bit PHY words into 32-bit uDMA words
// Odd last half is flushed with a zero upper half

module hyper_rx_pack
   import hyper_pkg::*;
(
   input  logic       sys_clk_i,
   input  logic       rst_i,
   input  logic       word_valid_i,
   input  phy_word_t  word_i,
   input  logic       word_last_i,
   output logic       ready_o,
   output udma_word_t rx_data_udma_o,
   output logic       rx_valid_udma_o,
   input  logic       rx_ready_udma_i
);

   phy_word_t low_q;
   logic      half_q;
   logic      flush_q;
   logic      out_free;
   logic      take;

   assign out_free = !rx_valid_udma_o || rx_ready_udma_i;
   // A lone last half waiting for the output blocks the next burst
   assign ready_o  = !((half_q && !out_free) || flush_q);
   assign take     = word_valid_i && ready_o;

   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
      begin
         half_q          <= 1'b0;
         flush_q         <= 1'b0;
         rx_valid_udma_o <= 1'b0;
      end
      else
      begin
         if (out_free)
            rx_valid_udma_o <= 1'b0;
         if (take && half_q)
         begin
            rx_valid_udma_o <= 1'b1;
            half_q          <= 1'b0;
         end
         else if (take && word_last_i && out_free)
            rx_valid_udma_o <= 1'b1;
         else if (take)
         begin
            half_q  <= 1'b1;
            flush_q <= word_last_i;
         end
         else if (flush_q && out_free)
         begin
            rx_valid_udma_o <= 1'b1;
            half_q          <= 1'b0;
            flush_q         <= 1'b0;
         end
      end
   end

   // First half of a pair lands in the low half
   always_ff @(posedge sys_clk_i)
   begin
      if (take && half_q)
         rx_data_udma_o <= {word_i, low_q};
      else if (take && word_last_i && out_free)
         rx_data_udma_o <= {16'h0000, word_i};
      else if (take)
         low_q <= word_i;
      else if (flush_q && out_free)
         rx_data_udma_o <= {16'h0000, low_q};
   end

endmodule

// ==== source/hyper_read_ctrl.sv ====
// Read controller
// One PHY burst per queued command, counts the returned words
// and reports completion with the channel id

module hyper_read_ctrl
   import hyper_pkg::*;
#(
   parameter int NB_CH = 4
)
(
   input  logic                                     sys_clk_i,
   input  logic                                     rst_i,

   input  logic                                     fifo_valid_i,
   input  hyper_cmd_t                               fifo_cmd_i,
   input  logic [(NB_CH>1 ? $clog2(NB_CH) : 1)-1:0] fifo_id_i,
   output logic                                     pop_o,

   output logic                                     trans_valid_o,
   input  logic                                     trans_ready_i,
   output phy_trans_t                               trans_o,

   input  logic                                     rx_valid_i,
   input  phy_word_t                                rx_data_i,
   output logic                                     rx_ready_o,

   input  logic                                     pack_ready_i,
   output logic                                     word_valid_o,
   output phy_word_t                                word_o,
   output logic                                     word_last_o,
   output logic                                     done_valid_o,
   output logic [(NB_CH>1 ? $clog2(NB_CH) : 1)-1:0] done_id_o
);

   localparam int ID_W = (NB_CH > 1) ? $clog2(NB_CH) : 1;

   ctrl_state_e     state_q;
   hyper_cmd_t      cmd_q;
   logic [ID_W-1:0] id_q;
   burst_len_t      remain_q;
   logic            rx_take;

   assign pop_o         = (state_q == IDLE) && fifo_valid_i;
   assign trans_valid_o = (state_q == ISSUE);
   assign trans_o       = '{address: cmd_q.addr, burst: cmd_q.len};

   //////////////////////////////////////////
   // Receive side
   //////////////////////////////////////////
   assign rx_ready_o   = (state_q == RECEIVE) && pack_ready_i;
   assign rx_take      = rx_valid_i && rx_ready_o;
   assign word_valid_o = rx_take;
   assign word_o       = rx_data_i;
   assign word_last_o  = (remain_q == burst_len_t'(1));
   assign done_valid_o = rx_take && word_last_o;
   assign done_id_o    = id_q;

   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
      begin
         state_q  <= IDLE;
         remain_q <= '0;
      end
      else
      begin
         case (state_q)
            IDLE:
            begin
               if (pop_o)
               begin
                  state_q  <= ISSUE;
                  remain_q <= fifo_cmd_i.len;
               end
            end
            ISSUE:
            begin
               if (trans_ready_i)
                  state_q <= RECEIVE;
            end
            RECEIVE:
            begin
               if (rx_take)
                  remain_q <= remain_q - 1'b1;
               if (done_valid_o)
                  state_q <= IDLE;
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge sys_clk_i)
   begin
      if (pop_o)
      begin
         cmd_q <= fifo_cmd_i;
         id_q  <= fifo_id_i;
      end
   end

endmodule

// ==== source/hyper_trans_fifo.sv ====
// Synchronous FIFO of tagged read commands
// Circular buffer with read and write pointers and an entry count

module hyper_trans_fifo
   import hyper_pkg::*;
#(
   parameter int NB_CH      = 4,
   parameter int FIFO_DEPTH = 4
)
(
   input  logic                                     sys_clk_i,
   input  logic                                     rst_i,
   input  logic                                     push_i,
   input  hyper_cmd_t                               cmd_i,
   input  logic [(NB_CH>1 ? $clog2(NB_CH) : 1)-1:0] id_i,
   output logic                                     full_o,
   input  logic                                     pop_i,
   output logic                                     valid_o,
   output hyper_cmd_t                               cmd_o,
   output logic [(NB_CH>1 ? $clog2(NB_CH) : 1)-1:0] id_o
);

   localparam int ID_W  = (NB_CH > 1) ? $clog2(NB_CH) : 1;
   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   hyper_cmd_t      cmd_mem [FIFO_DEPTH];
   logic [ID_W-1:0] id_mem  [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             do_pop;

   assign valid_o = (count_q != '0);
   assign full_o  = (count_q == CNT_W'(FIFO_DEPTH));
   assign do_pop  = pop_i && valid_o;
   assign cmd_o   = cmd_mem[rd_ptr_q];
   assign id_o    = id_mem[rd_ptr_q];

   always_ff @(posedge sys_clk_i)
   begin
      if (push_i)
      begin
         cmd_mem[wr_ptr_q] <= cmd_i;
         id_mem[wr_ptr_q]  <= id_i;
      end
   end

   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push_i)
            wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (do_pop)
            rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         case ({push_i, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

// ==== source/hyper_rr_arbiter.sv ====
// Round-robin arbiter over the channel command requests
// Grants only while the FIFO has room and tags the command with its id

module hyper_rr_arbiter
   import hyper_pkg::*;
#(
   parameter int NB_CH = 4
)
(
   input  logic                        sys_clk_i,
   input  logic                        rst_i,
   input  logic [NB_CH-1:0]            req_i,
   input  hyper_cmd_t [NB_CH-1:0]      cmd_i,
   input  logic                        full_i,
   output logic [NB_CH-1:0]            gnt_o,
   output logic                        push_o,
   output hyper_cmd_t                  cmd_o,
   output logic [(NB_CH>1 ? $clog2(NB_CH) : 1)-1:0] id_o
);

   localparam int ID_W = (NB_CH > 1) ? $clog2(NB_CH) : 1;

   logic [ID_W-1:0] last_q;
   logic [ID_W-1:0] sel;
   logic            found;

   // Search starts one past the last grant
   always_comb
   begin
      found = 1'b0;
      sel   = last_q;
      for (int k = 1; k <= NB_CH; k++)
      begin
         if (!found && req_i[(int'(last_q) + k) % NB_CH])
         begin
            found = 1'b1;
            sel   = ID_W'((int'(last_q) + k) % NB_CH);
         end
      end
   end

   assign push_o = found && !full_i;
   assign cmd_o  = cmd_i[sel];
   assign id_o   = sel;

   always_comb
   begin
      gnt_o = '0;
      if (push_o)
         gnt_o[sel] = 1'b1;
   end

   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
         last_q <= ID_W'(NB_CH - 1);
      else if (push_o)
         last_q <= sel;
   end

endmodule

// ==== source/hyper_chan_regs.sv ====
// Per-channel register file
// Address and length registers, busy flag,
// command request to the arbiter and end-of-transfer event

module hyper_chan_regs
   import hyper_pkg::*;
(
   input  logic       sys_clk_i,
   input  logic       rst_i,

   input  cfg_data_t  cfg_data_i,
   input  cfg_addr_t  cfg_addr_i,
   input  logic       cfg_valid_i,
   input  logic       cfg_rwn_i,
   output logic       cfg_ready_o,
   output cfg_data_t  cfg_data_o,

   output logic       cmd_req_o,
   output hyper_cmd_t cmd_o,
   input  logic       cmd_gnt_i,

   input  logic       done_i,
   output logic       evt_eot_o
);

   hyper_addr_t addr_q;
   burst_len_t  len_q;
   logic        busy_q;
   logic        start;

   // Start only counts while idle
   assign start = cfg_valid_i && !cfg_rwn_i && (cfg_addr_i == REG_CMD)
                  && cfg_data_i[0] && !busy_q;

   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
      begin
         addr_q      <= '0;
         len_q       <= '0;
         busy_q      <= 1'b0;
         cmd_req_o   <= 1'b0;
         cfg_ready_o <= 1'b0;
         evt_eot_o   <= 1'b0;
      end
      else
      begin
         cfg_ready_o <= cfg_valid_i;
         evt_eot_o   <= done_i;
         if (cfg_valid_i && !cfg_rwn_i && (cfg_addr_i == REG_ADDR))
            addr_q <= cfg_data_i;
         if (cfg_valid_i && !cfg_rwn_i && (cfg_addr_i == REG_LEN))
            len_q <= burst_len_t'(cfg_data_i);
         if (done_i)
            busy_q <= 1'b0;
         else if (start)
            busy_q <= 1'b1;
         if (start)
            cmd_req_o <= 1'b1;
         else if (cmd_gnt_i)
            cmd_req_o <= 1'b0;
      end
   end

   // Command snapshot taken at start
   always_ff @(posedge sys_clk_i)
   begin
      if (start)
      begin
         cmd_o.addr <= addr_q;
         cmd_o.len  <= len_q;
      end
   end

   always_ff @(posedge sys_clk_i)
   begin
      case (cfg_addr_i)
         REG_ADDR: cfg_data_o <= addr_q;
         REG_LEN:  cfg_data_o <= cfg_data_t'(len_q);
         REG_CMD:  cfg_data_o <= cfg_data_t'(busy_q);
         default:  cfg_data_o <= '0;
      endcase
   end

endmodule

// ==== source/hyper_pkg.sv ====
// Shared definitions for the HyperBus read path
// Widths, data typedefs, register offsets,
// command and PHY transaction structs, controller states

package hyper_pkg;

   localparam int HYPER_ADDR_W = 32;
   localparam int BURST_LEN_W  = 16;
   localparam int PHY_WORD_W   = 16;
   localparam int UDMA_WORD_W  = 32;
   localparam int CFG_DATA_W   = 32;
   localparam int CFG_ADDR_W   = 5;

   typedef logic [HYPER_ADDR_W-1:0] hyper_addr_t;
   // Length in 16-bit words, never zero
   typedef logic [BURST_LEN_W-1:0]  burst_len_t;
   typedef logic [PHY_WORD_W-1:0]   phy_word_t;
   typedef logic [UDMA_WORD_W-1:0]  udma_word_t;
   typedef logic [CFG_DATA_W-1:0]   cfg_data_t;
   typedef logic [CFG_ADDR_W-1:0]   cfg_addr_t;

   // Channel register map
   localparam cfg_addr_t REG_ADDR = 5'd0;
   localparam cfg_addr_t REG_LEN  = 5'd1;
   localparam cfg_addr_t REG_CMD  = 5'd2;

   typedef struct packed {
      hyper_addr_t addr;
      burst_len_t  len;
   } hyper_cmd_t;

   typedef struct packed {
      hyper_addr_t address;
      burst_len_t  burst;
   } phy_trans_t;

   typedef enum logic [1:0] {
      IDLE,
      ISSUE,
      RECEIVE
   } ctrl_state_e;

endpackage
